// ==== rtl/wb_config.svh ====
`ifndef WB_CONFIG_SVH
`define WB_CONFIG_SVH

// datapath width
`define XLEN        32

// architectural register file
`define RF_ADDR_W   5
`define REG_COUNT   32

// data memory, word addressed
`define MEM_AW      6
`define MEM_DEPTH   (1 << `MEM_AW)
`define LOAD_LAT    2

// exception entry points
`define EENTRY      32'h1c00_8000
`define TLBR_ENTRY  32'h1c00_c000
`define VPPN_W      19

`endif

// ==== rtl/wb_pkg.sv ====
`include "wb_config.svh"

package wb_pkg;

    typedef logic [`XLEN-1:0]      xlen_t;
    typedef logic [`RF_ADDR_W-1:0] reg_idx_t;
    typedef logic [`VPPN_W-1:0]    vppn_t;
    typedef logic [6:0]            ecode_t;

    // exception codes, address class first
    localparam ecode_t exc_pil  = 7'h01;
    localparam ecode_t exc_pis  = 7'h02;
    localparam ecode_t exc_pif  = 7'h03;
    localparam ecode_t exc_pme  = 7'h04;
    localparam ecode_t exc_ppi  = 7'h07;
    localparam ecode_t exc_adef = 7'h08;
    localparam ecode_t exc_ale  = 7'h09;
    localparam ecode_t exc_sys  = 7'h0b;
    localparam ecode_t exc_tlbr = 7'h3f;

    // slot 0 operation
    typedef enum logic [2:0] {
        op_alu, op_link, op_div, op_mod, op_load, op_store, op_csrrd, op_ertn
    } wb_op_t;

    // csr read select, low two bits of b0
    typedef enum logic [1:0] {csr_ecode, csr_badv, csr_era} csr_sel_t;

    typedef enum logic [1:0] {ds_idle, ds_run, ds_done} div_state_t;

    typedef enum logic [1:0] {st_empty, st_wait_long, st_retire} stage_state_t;

endpackage

// ==== rtl/wb_port_if.sv ====
// one writeback port into the register file
interface wb_port_if import wb_pkg::*; ();

    logic     we;
    reg_idx_t rd;
    xlen_t    data;
    logic     valid;

    modport source (
        output we, rd, data, valid
    );

    modport sink (
        input we, rd, data, valid
    );

endinterface

// ==== rtl/int_divider.sv ====
`include "wb_config.svh"

module int_divider import wb_pkg::*; (
    input  logic  clk,
    input  logic  aresetn,
    input  logic  div_start,
    input  xlen_t dividend,
    input  xlen_t divisor,
    output logic  div_done,
    output xlen_t quotient,
    output xlen_t remainder
);

    div_state_t state;
    logic [4:0] count;
    xlen_t      quo_q;
    xlen_t      rem_q;
    xlen_t      dsr_q;

    // partial remainder shifted left with next dividend bit
    logic [`XLEN:0] shifted;
    logic [`XLEN:0] diff;

    assign shifted = {rem_q, quo_q[`XLEN-1]};
    assign diff    = shifted - {1'b0, dsr_q};

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            state <= ds_idle;
            count <= '0;
        end else begin
            case (state)
                // done falls back to idle, so a back-to-back start is taken there too
                ds_idle, ds_done: begin
                    if (div_start) begin
                        state <= ds_run;
                        count <= '0;
                    end else begin
                        state <= ds_idle;
                    end
                end
                ds_run: begin
                    count <= count + 5'd1;
                    if (count == 5'd31) begin
                        state <= ds_done;
                    end
                end
                default: state <= ds_idle;
            endcase
        end
    end

    // datapath, one quotient bit per run cycle
    always_ff @(posedge clk) begin
        if ((state != ds_run) && div_start) begin
            quo_q <= dividend;
            rem_q <= '0;
            dsr_q <= divisor;
        end else if (state == ds_run) begin
            // restore unless the trial subtract went negative
            if (!diff[`XLEN]) begin
                rem_q <= diff[`XLEN-1:0];
            end else begin
                rem_q <= shifted[`XLEN-1:0];
            end
            quo_q <= {quo_q[`XLEN-2:0], ~diff[`XLEN]};
        end
    end

    // divisor zero falls out as all ones and the dividend
    assign div_done  = (state == ds_done);
    assign quotient  = quo_q;
    assign remainder = rem_q;

endmodule

// ==== rtl/load_unit.sv ====
`include "wb_config.svh"

module load_unit import wb_pkg::*; (
    input  logic              clk,
    input  logic              aresetn,
    input  logic              mem_req,
    input  logic              mem_we,
    input  logic [`MEM_AW-1:0] mem_addr,
    input  xlen_t             mem_wdata,
    output logic              mem_ready,
    output xlen_t             mem_rdata,
    output logic              mem_busy
);

    xlen_t mem [`MEM_DEPTH];

    logic               clearing;
    logic [`MEM_AW-1:0] clr_cnt;
    logic [`LOAD_LAT-1:0] vld_sr;
    logic               load_req;
    xlen_t              rdata_q;

    assign load_req = mem_req && !mem_we;

    // walk every word once after reset
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            clearing <= 1'b1;
            clr_cnt  <= '0;
        end else if (clearing) begin
            clr_cnt <= clr_cnt + 1'b1;
            if (&clr_cnt) begin
                clearing <= 1'b0;
            end
        end
    end

    // clear sweep has priority over stores
    always_ff @(posedge clk) begin
        if (clearing) begin
            mem[clr_cnt] <= '0;
        end else if (mem_req && mem_we) begin
            mem[mem_addr] <= mem_wdata;
        end
    end

    // load latency pipe
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            vld_sr <= '0;
        end else begin
            vld_sr <= {vld_sr[`LOAD_LAT-2:0], load_req};
        end
    end

    // one load in flight, so data is captured once and held
    always_ff @(posedge clk) begin
        if (load_req) begin
            rdata_q <= mem[mem_addr];
        end
    end

    assign mem_ready = vld_sr[`LOAD_LAT-1];
    assign mem_rdata = rdata_q;
    assign mem_busy  = clearing;

endmodule

// ==== rtl/exc_csr.sv ====
`include "wb_config.svh"

module exc_csr import wb_pkg::*; (
    input  logic     clk,
    input  logic     aresetn,
    input  logic     commit_exc,
    input  logic     commit_ertn,
    input  ecode_t   exc_code,
    input  xlen_t    exc_badv,
    input  xlen_t    exc_pc,
    input  csr_sel_t csr_sel,
    output xlen_t    csr_rdata,
    output logic     redirect_valid,
    output xlen_t    redirect_pc
);

    ecode_t ecode_q;
    xlen_t  badv_q;
    xlen_t  era_q;
    vppn_t  vppn_q;

    logic tlb_class;
    logic addr_class;

    // tlb class codes also carry a vppn
    assign tlb_class = (exc_code == exc_pil) || (exc_code == exc_pis) ||
                       (exc_code == exc_pif) || (exc_code == exc_pme) ||
                       (exc_code == exc_ppi) || (exc_code == exc_tlbr);
    assign addr_class = tlb_class || (exc_code == exc_adef) || (exc_code == exc_ale);

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            ecode_q <= '0;
            badv_q  <= '0;
            era_q   <= '0;
            vppn_q  <= '0;
        end else if (commit_exc) begin
            ecode_q <= exc_code;
            era_q   <= exc_pc;
            if (addr_class) begin
                badv_q <= exc_badv;
            end
            if (tlb_class) begin
                vppn_q <= exc_badv[31:13];
            end
        end
    end

    always_comb begin
        case (csr_sel)
            csr_ecode: csr_rdata = xlen_t'(ecode_q);
            csr_badv:  csr_rdata = badv_q;
            csr_era:   csr_rdata = era_q;
            // spare select shows the vppn for the refill handler
            default:   csr_rdata = {vppn_q, 13'd0};
        endcase
    end

    // ertn goes back to era, exceptions to their entry
    assign redirect_valid = commit_exc || commit_ertn;
    assign redirect_pc    = commit_exc ? ((exc_code == exc_tlbr) ? `TLBR_ENTRY : `EENTRY)
                                       : era_q;

endmodule

// ==== rtl/ex2_wb_stage.sv ====
`include "wb_config.svh"

module ex2_wb_stage import wb_pkg::*; (
    input  logic               clk,
    input  logic               aresetn,
    // incoming bundle
    input  logic               in_valid,
    output logic               in_ready,
    input  xlen_t              pc0,
    input  wb_op_t             op0,
    input  xlen_t              a0,
    input  xlen_t              b0,
    input  reg_idx_t           rd0,
    input  logic               exc0,
    input  ecode_t             ecode0,
    input  xlen_t              badv0,
    input  xlen_t              pc1,
    input  xlen_t              result1,
    input  reg_idx_t           rd1,
    input  logic               wen1,
    // divider
    output logic               div_start,
    output xlen_t              dividend,
    output xlen_t              divisor,
    input  logic               div_done,
    input  xlen_t              quotient,
    input  xlen_t              remainder,
    // data memory
    output logic               mem_req,
    output logic               mem_we,
    output logic [`MEM_AW-1:0] mem_addr,
    output xlen_t              mem_wdata,
    input  logic               mem_ready,
    input  logic               mem_busy,
    input  xlen_t              mem_rdata,
    // exception csr
    output logic               commit_exc,
    output logic               commit_ertn,
    output ecode_t             exc_code,
    output xlen_t              exc_badv,
    output xlen_t              exc_pc,
    output csr_sel_t           csr_sel,
    input  xlen_t              csr_rdata,
    // writeback
    wb_port_if.source          wb0,
    wb_port_if.source          wb1,
    output logic               wb_valid0,
    output logic               wb_valid1,
    output xlen_t              wb_pc0,
    output xlen_t              wb_pc1
);

    stage_state_t state;

    // registered bundle
    xlen_t    pc0_q, a0_q, b0_q, badv0_q, pc1_q, result1_q;
    wb_op_t   op0_q;
    reg_idx_t rd0_q, rd1_q;
    logic     exc0_q, wen1_q;
    ecode_t   ecode0_q;
    logic     mem_start_q;

    logic  accept, is_div_in, is_mem_in, long_in, long_done, retire_now;
    xlen_t data0;

    // a raised exception kills any unit request
    assign is_div_in = !exc0 && ((op0 == op_div) || (op0 == op_mod));
    assign is_mem_in = !exc0 && ((op0 == op_load) || (op0 == op_store));
    assign long_in   = is_div_in || (!exc0 && (op0 == op_load));

    assign long_done  = (op0_q == op_load) ? mem_ready : div_done;
    assign retire_now = (state == st_retire) || ((state == st_wait_long) && long_done);

    // allowin, also held low during the memory clear sweep
    assign in_ready = !mem_busy && ((state == st_empty) || retire_now);
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            state       <= st_empty;
            mem_start_q <= 1'b0;
        end else begin
            mem_start_q <= accept && is_mem_in;
            if (accept) begin
                state <= long_in ? st_wait_long : st_retire;
            end else if (retire_now) begin
                state <= st_empty;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pc0_q     <= pc0;
            op0_q     <= op0;
            a0_q      <= a0;
            b0_q      <= b0;
            rd0_q     <= rd0;
            exc0_q    <= exc0;
            ecode0_q  <= ecode0;
            badv0_q   <= badv0;
            pc1_q     <= pc1;
            result1_q <= result1;
            rd1_q     <= rd1;
            wen1_q    <= wen1;
        end
    end

    // divider is loaded straight from the bundle at acceptance
    assign div_start = accept && is_div_in;
    assign dividend  = a0;
    assign divisor   = b0;

    // memory request one cycle after acceptance
    assign mem_req   = mem_start_q;
    assign mem_we    = (op0_q == op_store);
    assign mem_addr  = a0_q[`MEM_AW+1:2];
    assign mem_wdata = b0_q;

    // slot 0 result select
    always_comb begin
        case (op0_q)
            op_link:  data0 = a0_q + xlen_t'(4);
            op_div:   data0 = quotient;
            op_mod:   data0 = remainder;
            op_load:  data0 = mem_rdata;
            op_csrrd: data0 = csr_rdata;
            default:  data0 = a0_q;
        endcase
    end

    assign commit_exc  = retire_now && exc0_q;
    assign commit_ertn = retire_now && !exc0_q && (op0_q == op_ertn);
    assign exc_code    = ecode0_q;
    assign exc_badv    = badv0_q;
    assign exc_pc      = pc0_q;
    assign csr_sel     = csr_sel_t'(b0_q[1:0]);

    // no write for store, ertn, or any exception bundle
    assign wb0.valid = retire_now;
    assign wb0.we    = retire_now && !exc0_q && (op0_q != op_store) && (op0_q != op_ertn);
    assign wb0.rd    = rd0_q;
    assign wb0.data  = data0;

    assign wb1.valid = retire_now;
    assign wb1.we    = retire_now && wen1_q && !exc0_q;
    assign wb1.rd    = rd1_q;
    assign wb1.data  = result1_q;

    // both slots retire together
    assign wb_valid0 = retire_now;
    assign wb_valid1 = retire_now;
    assign wb_pc0    = pc0_q;
    assign wb_pc1    = pc1_q;

endmodule

// ==== rtl/regfile.sv ====
`include "wb_config.svh"

module regfile import wb_pkg::*; (
    input  logic          clk,
    input  logic          aresetn,
    wb_port_if.sink       wb0,
    wb_port_if.sink       wb1,
    input  reg_idx_t      raddr,
    output xlen_t         rdata
);

    xlen_t regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (!aresetn) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // r0 stays zero
            if (wb0.valid && wb0.we && (wb0.rd != '0)) begin
                regs[wb0.rd] <= wb0.data;
            end
            // slot 1 is younger, last assignment wins on same rd
            if (wb1.valid && wb1.we && (wb1.rd != '0)) begin
                regs[wb1.rd] <= wb1.data;
            end
        end
    end

    // debug read, combinational
    assign rdata = regs[raddr];

endmodule

// ==== rtl/backend_top.sv ====
`include "wb_config.svh"

module backend_top import wb_pkg::*; (
    input  logic     clk,
    input  logic     aresetn,
    input  logic     in_valid,
    output logic     in_ready,
    input  xlen_t    pc0,
    input  wb_op_t   op0,
    input  xlen_t    a0,
    input  xlen_t    b0,
    input  reg_idx_t rd0,
    input  logic     exc0,
    input  ecode_t   ecode0,
    input  xlen_t    badv0,
    input  xlen_t    pc1,
    input  xlen_t    result1,
    input  reg_idx_t rd1,
    input  logic     wen1,
    input  reg_idx_t rf_raddr,
    output logic     wb_valid0,
    output xlen_t    wb_pc0,
    output logic     wb_we0,
    output reg_idx_t wb_rd0,
    output xlen_t    wb_data0,
    output logic     wb_valid1,
    output xlen_t    wb_pc1,
    output logic     wb_we1,
    output reg_idx_t wb_rd1,
    output xlen_t    wb_data1,
    output logic     redirect_valid,
    output xlen_t    redirect_pc,
    output xlen_t    rf_rdata
);

    logic               div_start, div_done;
    xlen_t              dividend, divisor, quotient, remainder;
    logic               mem_req, mem_we, mem_ready, mem_busy;
    logic [`MEM_AW-1:0] mem_addr;
    xlen_t              mem_wdata, mem_rdata;
    logic               commit_exc, commit_ertn;
    ecode_t             exc_code;
    xlen_t              exc_badv, exc_pc, csr_rdata;
    csr_sel_t           csr_sel;

    wb_port_if wb0 ();
    wb_port_if wb1 ();

    ex2_wb_stage u_stage (.*);

    int_divider u_div (.*);

    load_unit u_mem (.*);

    exc_csr u_csr (.*);

    regfile u_rf (
        .clk    (clk),
        .aresetn(aresetn),
        .wb0    (wb0),
        .wb1    (wb1),
        .raddr  (rf_raddr),
        .rdata  (rf_rdata)
    );

    // retire ports mirror the writeback bundles
    assign wb_we0   = wb0.we;
    assign wb_rd0   = wb0.rd;
    assign wb_data0 = wb0.data;
    assign wb_we1   = wb1.we;
    assign wb_rd1   = wb1.rd;
    assign wb_data1 = wb1.data;

endmodule

// ==== dv/backend_chk.sv ====
module backend_chk (
    input logic clk,
    input logic aresetn,
    input logic in_ready,
    input logic div_start,
    input logic div_done,
    input logic wb_valid0,
    input logic wb_we0,
    input logic redirect_valid
);

    logic div_pending;

    // set by the start pulse, cleared when the quotient comes back
    always_ff @(posedge clk) begin
        if (!aresetn) begin
            div_pending <= 1'b0;
        end else if (div_start) begin
            div_pending <= 1'b1;
        end else if (div_done) begin
            div_pending <= 1'b0;
        end
    end

    // allowin stays low until the divide retires
    a_div_stall: assert property (@(posedge clk) disable iff (!aresetn)
        div_pending && !div_done |-> !in_ready)
        else $error("in_ready high while a divide is pending");

    a_redir_retire: assert property (@(posedge clk) disable iff (!aresetn)
        redirect_valid |-> wb_valid0)
        else $error("redirect without a slot 0 retire");

    // redirecting bundles never write slot 0
    a_redir_nowrite: assert property (@(posedge clk) disable iff (!aresetn)
        redirect_valid |-> !wb_we0)
        else $error("slot 0 write in a redirect cycle");

    a_reset_quiet: assert property (@(posedge clk) !aresetn |=> !wb_valid0)
        else $error("retire in the cycle after reset");

endmodule

bind backend_top backend_chk u_chk (
    .clk           (clk),
    .aresetn       (aresetn),
    .in_ready      (in_ready),
    .div_start     (div_start),
    .div_done      (div_done),
    .wb_valid0     (wb_valid0),
    .wb_we0        (wb_we0),
    .redirect_valid(redirect_valid)
);

// ==== dv/backend_tb.sv ====
`include "wb_config.svh"

module backend_tb import wb_pkg::*; ();

    localparam int TMO = 200;

    logic     clk, aresetn, in_valid, in_ready, exc0, wen1;
    logic     wb_valid0, wb_we0, wb_valid1, wb_we1, redirect_valid;
    xlen_t    pc0, a0, b0, badv0, pc1, result1, rf_rdata;
    xlen_t    wb_pc0, wb_data0, wb_pc1, wb_data1, redirect_pc;
    wb_op_t   op0;
    reg_idx_t rd0, rd1, rf_raddr, wb_rd0, wb_rd1;
    ecode_t   ecode0;

    // expected retire, queued at acceptance in program order
    typedef struct packed {
        xlen_t       pc0, data0, pc1, data1, rpc;
        reg_idx_t    rd0, rd1;
        logic        we0, we1, redir, is_div;
        logic [31:0] acc_cyc, lat;
    } exp_t;

    exp_t exp_q [$];

    // shadow architectural state
    xlen_t  sh_rf [`REG_COUNT];
    xlen_t  sh_mem [`MEM_DEPTH];
    ecode_t sh_ecode;
    xlen_t  sh_badv, sh_era;

    logic [31:0] lfsr = 32'h9b32_4439;
    logic [31:0] cyc = '0;
    int checks, errors, tests, failed_tests, err_mark;

    backend_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 32'd1;

    // x^32 + x^22 + x^2 + x + 1, one step per bit taken
    function automatic xlen_t rand_bits(input int n);
        xlen_t v;
        logic  fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // codes that carry a bad virtual address
    function automatic logic addr_code(input ecode_t ec);
        return ec inside {exc_pil, exc_pis, exc_pif, exc_pme, exc_ppi,
                          exc_adef, exc_ale, exc_tlbr};
    endfunction

    function automatic void ref_retire(input wb_op_t op, input xlen_t a, input xlen_t b,
            input logic exc, input ecode_t ec, input logic wen, output xlen_t d0,
            output logic we0, output logic we1, output logic redir, output xlen_t rpc);
        we0   = !exc && (op != op_store) && (op != op_ertn);
        we1   = wen && !exc;
        redir = exc || (op == op_ertn);
        // refill has its own entry, ertn returns to era
        rpc   = exc ? ((ec == exc_tlbr) ? `TLBR_ENTRY : `EENTRY) : sh_era;
        case (op)
            op_link:  d0 = a + 32'd4;
            op_div:   d0 = (b == '0) ? '1 : a / b;
            op_mod:   d0 = (b == '0) ? a : a % b;
            op_load:  d0 = sh_mem[a[7:2]];
            op_csrrd: d0 = (b[1:0] == 2'd0) ? xlen_t'(sh_ecode) :
                           (b[1:0] == 2'd1) ? sh_badv : sh_era;
            default:  d0 = a;
        endcase
    endfunction

    task automatic abort_run(input string why);
        $display("ERROR at %0t: %s", $time, why);
        $display("=== FAIL ===");
        $finish;
    endtask

    task automatic check_word(input string name, input xlen_t got, input xlen_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, want);
        end
    endtask

    task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, want);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, want);
        end
    endtask

    // drive one bundle, hold it until accepted, then update the shadow state
    task automatic send(input wb_op_t op, input xlen_t a, input xlen_t b, input reg_idx_t r0,
            input logic exc, input ecode_t ec, input xlen_t bv, input reg_idx_t r1,
            input logic wen);
        exp_t e;
        int   waited;
        e.pc0    = rand_bits(32) & 32'hffff_fffc;
        e.pc1    = e.pc0 + 32'd4;
        e.data1  = rand_bits(32);
        e.rd0    = r0;
        e.rd1    = r1;
        e.is_div = !exc && (op inside {op_div, op_mod});
        // one cycle per quotient bit, then the retire cycle
        e.lat    = e.is_div ? `XLEN + 1 : ((!exc && (op == op_load)) ? `LOAD_LAT + 1 : 1);
        ref_retire(op, a, b, exc, ec, wen, e.data0, e.we0, e.we1, e.redir, e.rpc);
        @(posedge clk);
        in_valid <= 1'b1;
        pc0      <= e.pc0;
        op0      <= op;
        a0       <= a;
        b0       <= b;
        rd0      <= r0;
        exc0     <= exc;
        ecode0   <= ec;
        badv0    <= bv;
        pc1      <= e.pc1;
        result1  <= e.data1;
        rd1      <= r1;
        wen1     <= wen;
        // in_ready only moves at the clock edge
        waited = 0;
        @(negedge clk);
        while (!in_ready && waited < TMO) begin
            @(negedge clk);
            waited++;
        end
        if (!in_ready) begin
            abort_run("bundle was never accepted");
        end else begin
            @(posedge clk);
            e.acc_cyc = cyc;
            in_valid <= 1'b0;
            exp_q.push_back(e);
            // slot 1 applied last, the younger one wins
            if (e.we0 && (r0 != '0)) sh_rf[r0] = e.data0;
            if (e.we1 && (r1 != '0)) sh_rf[r1] = e.data1;
            if (!exc && (op == op_store)) sh_mem[a[7:2]] = b;
            if (exc) begin
                sh_ecode = ec;
                sh_era   = e.pc0;
                if (addr_code(ec)) sh_badv = bv;
            end
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while ((exp_q.size() != 0) && (waited < TMO)) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            abort_run("retire did not arrive in time");
        end
    endtask

    // sweep the debug port over every register
    task automatic check_regfile();
        for (int i = 0; i < `REG_COUNT; i++) begin
            @(posedge clk);
            rf_raddr <= reg_idx_t'(i);
            @(negedge clk);
            check_word("rf_rdata", rf_rdata, sh_rf[i]);
        end
    endtask

    task automatic end_test(input string name);
        drain();
        check_regfile();
        tests++;
        if (errors != err_mark) failed_tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - err_mark);
        err_mark = errors;
    endtask

    // compare at the falling edge, outputs settled
    initial begin
        exp_t e;
        forever begin
            @(negedge clk);
            if (aresetn && wb_valid0) begin
                if (exp_q.size() == 0) begin
                    abort_run("retire with no bundle in flight");
                end else begin
                    e = exp_q.pop_front();
                    check_word("wb_pc0", wb_pc0, e.pc0);
                    check_word("wb_pc1", wb_pc1, e.pc1);
                    check_bit("wb_valid1", wb_valid1, 1'b1);
                    check_bit("wb_we0", wb_we0, e.we0);
                    check_bit("wb_we1", wb_we1, e.we1);
                    if (e.we0) check_reg("wb_rd0", wb_rd0, e.rd0);
                    if (e.we0) check_word("wb_data0", wb_data0, e.data0);
                    if (e.we1) check_reg("wb_rd1", wb_rd1, e.rd1);
                    if (e.we1) check_word("wb_data1", wb_data1, e.data1);
                    check_bit("redirect_valid", redirect_valid, e.redir);
                    if (e.redir) check_word("redirect_pc", redirect_pc, e.rpc);
                    check_word("latency", cyc - e.acc_cyc, e.lat);
                end
            end else if (aresetn) begin
                check_bit("redirect_valid", redirect_valid, 1'b0);
                // divide in flight holds allowin low
                if ((exp_q.size() != 0) && exp_q[0].is_div) check_bit("in_ready", in_ready, 1'b0);
            end
        end
    end

    initial begin
        reg_idx_t r;
        xlen_t    d;
        ecode_t   codes [4];
        codes = '{exc_pil, exc_adef, exc_ale, exc_tlbr};
        foreach (sh_rf[i]) sh_rf[i] = '0;
        foreach (sh_mem[i]) sh_mem[i] = '0;
        sh_ecode = '0;
        sh_badv  = '0;
        sh_era   = '0;
        aresetn  <= 1'b0;
        in_valid <= 1'b0;
        pc0      <= '0;
        op0      <= op_alu;
        a0       <= '0;
        b0       <= '0;
        rd0      <= '0;
        exc0     <= 1'b0;
        ecode0   <= '0;
        badv0    <= '0;
        pc1      <= '0;
        result1  <= '0;
        rd1      <= '0;
        wen1     <= 1'b0;
        rf_raddr <= '0;
        repeat (4) @(posedge clk);
        aresetn <= 1'b1;

        // every fourth bundle puts both slots on one rd
        for (int i = 0; i < 16; i++) begin
            r = reg_idx_t'(rand_bits(5));
            send((i % 2) ? op_link : op_alu, rand_bits(32), '0, r, 1'b0, '0, '0,
                 (i % 4 == 3) ? r : reg_idx_t'(rand_bits(5)), 1'b1);
        end
        end_test("alu and link");

        // divisor zero on every third one
        for (int i = 0; i < 8; i++) begin
            d = (i % 3 == 0) ? '0 : (rand_bits(32) >> rand_bits(5));
            send((i % 2) ? op_mod : op_div, rand_bits(32), d, reg_idx_t'(rand_bits(5)),
                 1'b0, '0, '0, reg_idx_t'(rand_bits(5)), 1'b1);
        end
        end_test("divide and modulo");

        // stores stay in the lower half, upper half is never written
        for (int i = 0; i < 4; i++) begin
            d = rand_bits(5) << 2;
            send(op_store, d, rand_bits(32), '0, 1'b0, '0, '0, '0, 1'b0);
            send(op_load, d, '0, reg_idx_t'(rand_bits(5)), 1'b0, '0, '0, '0, 1'b0);
        end
        send(op_load, 32'h80 | (rand_bits(5) << 2), '0, 5'd7, 1'b0, '0, '0, '0, 1'b0);
        end_test("store and load");

        foreach (codes[i]) begin
            send(op_alu, rand_bits(32), '0, 5'd3, 1'b1, codes[i], rand_bits(32), 5'd4, 1'b1);
            for (int s = 0; s < 3; s++) begin
                send(op_csrrd, '0, xlen_t'(s), reg_idx_t'(5'd8 + s), 1'b0, '0, '0, '0, 1'b0);
            end
        end
        end_test("address exceptions");

        send(op_alu, rand_bits(32), '0, 5'd5, 1'b1, exc_sys, rand_bits(32), 5'd6, 1'b1);
        for (int s = 0; s < 3; s++) begin
            send(op_csrrd, '0, xlen_t'(s), reg_idx_t'(5'd12 + s), 1'b0, '0, '0, '0, 1'b0);
        end
        end_test("syscall exception");

        send(op_ertn, rand_bits(32), '0, 5'd9, 1'b0, '0, '0, 5'd10, 1'b1);
        end_test("ertn");

        $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed_tests,
                 checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+rtl
rtl/wb_pkg.sv
rtl/wb_port_if.sv
rtl/int_divider.sv
rtl/load_unit.sv
rtl/exc_csr.sv
rtl/ex2_wb_stage.sv
rtl/regfile.sv
rtl/backend_top.sv
dv/backend_chk.sv
dv/backend_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= backend_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing
SIM_ARGS  ?=
SRCS      := $(shell grep -v '^+' $(FILELIST)) rtl/wb_config.svh

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# the log decides the exit status
run: build
	$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q '^=== PASS ===$$' $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
